// ==== sim.f ====
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/core_top.sv
tests/core_sva.sv
tests/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Test completed successfully

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/core_tb.sv ====
`timescale 1ns/10ps
module core_tb;
    import core_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        imem_ack;
    retire_t     retire;

    logic [31:0] mem [64];
    retire_t     exp_all [$];   // Architectural retire sequence
    retire_t     exp_q [$];     // What the current pass still owes
    retire_t     exp_ent;
    logic [31:0] m_regs [16];
    flags_t      m_flags;
    logic [31:0] lfsr;
    logic        random_mode;
    int          prog_len;
    int          max_delay = 3;
    int          delay;
    int          cycles;
    int          cycle_limit;

    core_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_ack   (imem_ack),
        .retire     (retire)
    );

    bind fetch_unit core_sva u_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int next_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin  // One step per bit
            d = d * 2 + int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return d;
    endfunction

    function automatic logic [31:0] enc_imm(logic [3:0] cond, logic [3:0] op, logic s,
                                            logic [3:0] rn, logic [3:0] rd,
                                            logic [3:0] rot, logic [7:0] imm8);
        return {cond, 3'b001, op, s, rn, rd, rot, imm8};
    endfunction

    function automatic logic [31:0] enc_reg(logic [3:0] cond, logic [3:0] op, logic s,
                                            logic [3:0] rn, logic [3:0] rd, logic [4:0] amt,
                                            logic [1:0] sh, logic [3:0] rm);
        return {cond, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
    endfunction

    function automatic logic [31:0] enc_branch(logic [3:0] cond, int from, int to);
        logic [23:0] off;
        off = 24'(to - from - 2);  // Relative to pc+8
        return {cond, 3'b101, 1'b0, off};
    endfunction

    function automatic void emit_word(logic [31:0] w);
        mem[prog_len] = w;
        prog_len++;
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++)
            mem[i] = {4'he, 3'b101, 1'b1, 24'(i)};  // BL, dropped by decode
        prog_len = 0;
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd1, 4'd0, 8'hff));
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd2, 4'd4, 8'hff));
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd3, 4'd1, 8'h3f));
        emit_word(enc_reg(cond_al, op_add, 1'b0, 4'd3, 4'd4, 5'd4, shift_lsl, 4'd1));
        emit_word(enc_reg(cond_al, op_sub, 1'b0, 4'd4, 4'd5, 5'd8, shift_lsr, 4'd2));
        emit_word(enc_reg(cond_al, op_eor, 1'b0, 4'd5, 4'd6, 5'd4, shift_asr, 4'd2));
        emit_word(enc_reg(cond_al, op_orr, 1'b0, 4'd6, 4'd7, 5'd4, shift_ror, 4'd3));
        emit_word(enc_reg(cond_al, op_and, 1'b0, 4'd7, 4'd8, 5'd0, shift_ror, 4'd1)); // RRX
        emit_word(enc_reg(cond_al, op_mov, 1'b1, 4'd0, 4'd9, 5'd1, shift_lsl, 4'd2));
        emit_word(enc_reg(cond_al, op_add, 1'b1, 4'd2, 4'd10, 5'd0, shift_lsl, 4'd2));
        emit_word(enc_reg(cond_al, op_sub, 1'b1, 4'd1, 4'd11, 5'd0, shift_lsl, 4'd1));
        emit_word(enc_reg(cond_al, op_cmp, 1'b1, 4'd1, 4'd0, 5'd0, shift_lsl, 4'd2));
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd12, 4'd1, 8'h02));
        emit_word(enc_reg(cond_al, op_sub, 1'b1, 4'd12, 4'd13, 5'd0, shift_lsl, 4'd1));
        // Conditional moves under the overflow flags
        emit_word(enc_imm(cond_eq, op_mov, 1'b0, 4'd0, 4'd0, 4'd0, 8'h01));
        emit_word(enc_imm(cond_vs, op_mov, 1'b0, 4'd0, 4'd0, 4'd0, 8'h02));
        emit_word(enc_imm(cond_lt, op_mov, 1'b0, 4'd0, 4'd1, 4'd0, 8'h03));
        emit_word(enc_imm(cond_ge, op_mov, 1'b0, 4'd0, 4'd0, 4'd0, 8'h04));
        emit_word(enc_imm(cond_al, op_cmp, 1'b1, 4'd0, 4'd0, 4'd0, 8'h02));
        emit_word(enc_branch(cond_ne, prog_len, 25));  // Not taken
        emit_word(enc_branch(cond_eq, prog_len, 23));
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd0, 4'd0, 8'h55));
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd0, 4'd0, 8'h66));
        emit_word(enc_imm(cond_al, op_add, 1'b1, 4'd0, 4'd0, 4'd0, 8'h01));
        emit_word(enc_branch(cond_al, prog_len, 27));
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd5, 4'd0, 8'h01));
        emit_word(enc_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd5, 4'd0, 8'h02));
        emit_word(enc_reg(cond_al, op_mov, 1'b1, 4'd0, 4'd14, 5'd0, shift_lsr, 4'd0));
        emit_word(enc_reg(cond_al, op_mov, 1'b0, 4'd0, 4'd14, 5'd0, shift_asr, 4'd12));
        emit_word(enc_branch(cond_al, prog_len, prog_len));  // Park here
    endtask

    function automatic logic cond_holds(logic [3:0] c, flags_t fl);
        case (c)
            4'h0: return fl.z;
            4'h1: return !fl.z;
            4'h2: return fl.c;
            4'h3: return !fl.c;
            4'h4: return fl.n;
            4'h5: return !fl.n;
            4'h6: return fl.v;
            4'h7: return !fl.v;
            4'h8: return fl.c && !fl.z;
            4'h9: return !fl.c || fl.z;
            4'ha: return fl.n == fl.v;
            4'hb: return fl.n != fl.v;
            4'hc: return !fl.z && (fl.n == fl.v);
            4'hd: return fl.z || (fl.n != fl.v);
            default: return 1'b1;
        endcase
    endfunction

    // Returns {carry, value} of the second operand
    function automatic logic [32:0] operand2(logic [31:0] w, logic [31:0] rm, logic cin);
        logic [31:0] v;
        int          n;
        if (w[25]) begin
            n = 2 * int'(w[11:8]);
            v = {24'd0, w[7:0]};
            if (n != 0)
                v = (v >> n) | (v << (32 - n));
            return {(n == 0) ? cin : v[31], v};
        end
        n = int'(w[11:7]);
        case (w[6:5])
            2'd0: return (n == 0) ? {cin, rm} : {rm[32 - n], rm << n};
            2'd1: return (n == 0) ? {rm[31], 32'd0} : {rm[n - 1], rm >> n};
            2'd2: return (n == 0) ? {rm[31], {32{rm[31]}}}
                                  : {rm[n - 1], 32'($signed(rm) >>> n)};
            default: begin
                if (n == 0)
                    return {rm[0], cin, rm[31:1]};
                v = (rm >> n) | (rm << (32 - n));
                return {v[31], v};
            end
        endcase
    endfunction

    function automatic logic [31:0] model_reg(logic [3:0] r, logic [31:0] pc);
        return (r == 4'd15) ? pc + 32'd8 : m_regs[r];
    endfunction

    // Runs the program architecturally until the branch to itself
    function automatic void build_expected();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] target;
        logic [32:0] sh;
        logic [32:0] sum;
        flags_t      nf;
        retire_t     ent;
        logic        done;
        int          steps;
        pc = 32'd0;
        done = 1'b0;
        steps = 0;
        m_flags = '0;
        for (int i = 0; i < 16; i++)
            m_regs[i] = 32'd0;
        exp_all.delete();
        while (!done && steps < 1000) begin
            w = mem[pc[7:2]];
            steps++;
            if (w[27:25] == 3'b101) begin
                target = pc + 32'd8 + {{6{w[23]}}, w[23:0], 2'b00};
                done = cond_holds(w[31:28], m_flags) && (target == pc);
                pc = cond_holds(w[31:28], m_flags) ? target : pc + 32'd4;
            end else begin
                if (cond_holds(w[31:28], m_flags)) begin
                    a = model_reg(w[19:16], pc);
                    sh = operand2(w, model_reg(w[3:0], pc), m_flags.c);
                    nf = m_flags;
                    nf.c = sh[32];
                    case (w[24:21])
                        4'h0: res = a & sh[31:0];
                        4'h1: res = a ^ sh[31:0];
                        4'hc: res = a | sh[31:0];
                        4'hd: res = sh[31:0];
                        4'h4: begin
                            sum = {1'b0, a} + {1'b0, sh[31:0]};
                            res = sum[31:0];
                            nf.c = sum[32];
                            nf.v = (a[31] == sh[31]) && (res[31] != a[31]);
                        end
                        default: begin  // SUB and CMP
                            sum = {1'b0, a} - {1'b0, sh[31:0]};
                            res = sum[31:0];
                            nf.c = !sum[32];  // No borrow
                            nf.v = (a[31] != sh[31]) && (res[31] != a[31]);
                        end
                    endcase
                    nf.n = res[31];
                    nf.z = (res == 32'd0);
                    if (w[20])
                        m_flags = nf;
                    ent.valid = 1'b1;
                    ent.writes_rd = (w[24:21] != 4'ha);
                    ent.rd = w[15:12];
                    ent.data = res;
                    ent.flags = m_flags;
                    if (ent.writes_rd)
                        m_regs[ent.rd] = res;
                    exp_all.push_back(ent);
                end
                pc = pc + 32'd4;
            end
        end
    endfunction

    // Instruction memory, four-phase responder
    always begin
        @(posedge clk);
        #1;
        if (!rst_n) begin
            imem_ack = 1'b0;
        end else if (imem_req && !imem_ack) begin
            delay = random_mode ? next_delay() : 0;
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            imem_rdata = mem[imem_addr[7:2]];
            imem_ack = 1'b1;
        end else if (imem_ack && !imem_req) begin
            // Ack may linger after req drops
            delay = random_mode ? next_delay() : 0;
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            imem_ack = 1'b0;
        end
    end

    // Retire comparator
    always begin
        @(posedge clk);
        #1;
        if (rst_n && retire.valid) begin
            if (exp_q.size() == 0)
                abort_run("An instruction retired after the program was done");
            exp_ent = exp_q.pop_front();
            check_value("writes_rd", {31'd0, retire.writes_rd}, {31'd0, exp_ent.writes_rd});
            check_value("rd", {28'd0, retire.rd}, {28'd0, exp_ent.rd});
            if (exp_ent.writes_rd)
                check_value("data", retire.data, exp_ent.data);
            check_value("flags", {28'd0, retire.flags}, {28'd0, exp_ent.flags});
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit)
            abort_run($sformatf("Timeout after %0d cycles, %0d retires still missing",
                                cycles, exp_q.size()));
    end

    task automatic run_pass();
        if (rst_n) begin  // Reset on a finished handshake
            do begin
                @(posedge clk);
                #2;
            end while (!imem_ack);
        end
        rst_n = 1'b0;
        exp_q = exp_all;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (12) @(posedge clk);  // Nothing more may retire
    endtask

    initial begin
        rst_n = 1'b0;
        imem_ack = 1'b0;
        imem_rdata = 32'd0;
        random_mode = 1'b0;
        lfsr = 32'hcf80_9034;
        cycles = 0;
        load_program();
        build_expected();
        // Worst fetch is two cycles plus both handshake delays
        cycle_limit = 2 * prog_len * (2 * max_delay + 2) * 4;
        for (int pass = 0; pass < 2; pass++) begin
            random_mode = (pass == 1);
            run_pass();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== tests/core_sva.sv ====
`timescale 1ns/10ps
module core_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        imem_req,
    input logic [31:0] imem_addr,
    input logic        imem_ack
);

    // Request must wait for the ack
    req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req
    ) else $error("imem_req dropped before imem_ack was seen");

    addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_req |=> !imem_req || $stable(imem_addr)
    ) else $error("imem_addr changed during an open request");

    // Four-phase rule, ack low before the next request
    no_early_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_ack && !imem_req |=> !imem_req
    ) else $error("imem_req raised while imem_ack was still high");

endmodule

// ==== hdl/core_top.sv ====
`timescale 1ns/10ps
module core_top (
    input  logic              clk,
    input  logic              rst_n,
    output logic              imem_req,
    output logic [31:0]       imem_addr,
    input  logic [31:0]       imem_rdata,
    input  logic              imem_ack,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    fetch_t      fetch;
    uop_t        uop;
    redirect_t   redirect;
    retire_t     result;
    flags_t      flags;
    logic        cur_tag;
    logic [3:0]  rn_addr;
    logic [3:0]  rm_addr;
    logic [31:0] rn_data;
    logic [31:0] rm_data;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_ack   (imem_ack),
        .fetch      (fetch),
        .cur_tag    (cur_tag)
    );

    decode_stage u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetch   (fetch),
        .cur_tag (cur_tag),
        .uop     (uop)
    );

    // Retire output doubles as the bypass source
    execute_stage u_execute (
        .uop        (uop),
        .rf_rn_addr (rn_addr),
        .rf_rm_addr (rm_addr),
        .rf_rn_data (rn_data),
        .rf_rm_data (rm_data),
        .flags      (flags),
        .pending    (retire),
        .redirect   (redirect),
        .result     (result)
    );

    result_stage u_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .result  (result),
        .rn_addr (rn_addr),
        .rm_addr (rm_addr),
        .rn_data (rn_data),
        .rm_data (rm_data),
        .flags   (flags),
        .retire  (retire)
    );

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/10ps
module result_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::retire_t result,
    input  logic [3:0]        rn_addr,
    input  logic [3:0]        rm_addr,
    output logic [31:0]       rn_data,
    output logic [31:0]       rm_data,
    output core_pkg::flags_t  flags,
    output core_pkg::retire_t retire
);

    logic [31:0] regs [16];

    // Retire register, also the pending entry execute bypasses from
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            retire <= '0;
        else
            retire <= result;
    end

    // Register file trails the retire register by one edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= 32'd0;
        end else if (retire.valid && retire.writes_rd) begin
            regs[retire.rd] <= retire.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flags <= '0;
        else if (retire.valid)
            flags <= retire.flags;  // Unchanged value when S was clear
    end

    assign rn_data = regs[rn_addr];
    assign rm_data = regs[rm_addr];

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps
module execute_stage (
    input  core_pkg::uop_t      uop,
    output logic [3:0]          rf_rn_addr,
    output logic [3:0]          rf_rm_addr,
    input  logic [31:0]         rf_rn_data,
    input  logic [31:0]         rf_rm_data,
    input  core_pkg::flags_t    flags,
    input  core_pkg::retire_t   pending,
    output core_pkg::redirect_t redirect,
    output core_pkg::retire_t   result
);
    import core_pkg::*;

    flags_t      f;       // Flags this instruction sees
    flags_t      nf;
    logic [31:0] a;
    logic [31:0] rm_val;
    logic [31:0] op2;
    logic [31:0] res;
    logic        sh_c;    // Shifter carry-out
    logic [32:0] lsl_w;
    logic [32:0] lsr_w;
    logic [32:0] asr_w;
    logic [31:0] ror_w;
    logic [32:0] sum;
    logic        cond_ok;

    // r15 reads as pc+8; the pending retire is not in the file yet
    function automatic logic [31:0] read_reg(logic [3:0] addr, logic [31:0] rf_data,
                                             logic [31:0] pc, retire_t pend);
        if (addr == 4'd15)
            return pc + 32'd8;
        if (pend.valid && pend.writes_rd && pend.rd == addr)
            return pend.data;
        return rf_data;
    endfunction

    function automatic logic cond_pass(cond_e c, flags_t fl);
        case (c)
            cond_eq: return fl.z;
            cond_ne: return !fl.z;
            cond_cs: return fl.c;
            cond_cc: return !fl.c;
            cond_mi: return fl.n;
            cond_pl: return !fl.n;
            cond_vs: return fl.v;
            cond_vc: return !fl.v;
            cond_hi: return fl.c && !fl.z;
            cond_ls: return !fl.c || fl.z;
            cond_ge: return fl.n == fl.v;
            cond_lt: return fl.n != fl.v;
            cond_gt: return !fl.z && (fl.n == fl.v);
            cond_le: return fl.z || (fl.n != fl.v);
            default: return 1'b1;  // AL
        endcase
    endfunction

    assign rf_rn_addr = uop.rn;
    assign rf_rm_addr = uop.rm;
    assign a       = read_reg(uop.rn, rf_rn_data, uop.pc, pending);
    assign rm_val  = read_reg(uop.rm, rf_rm_data, uop.pc, pending);
    assign f       = pending.valid ? pending.flags : flags;
    assign cond_ok = cond_pass(uop.cond, f);

    // Low bit of the right shifts holds the last bit shifted out
    assign lsl_w = {1'b0, rm_val} << uop.imm5;
    assign lsr_w = {rm_val, 1'b0} >> uop.imm5;
    assign asr_w = $signed({rm_val, 1'b0}) >>> uop.imm5;
    assign ror_w = (rm_val >> uop.imm5) | (rm_val << (6'd32 - {1'b0, uop.imm5}));

    always_comb begin
        op2  = rm_val;
        sh_c = f.c;
        if (uop.use_imm) begin
            op2 = uop.imm_val;
            if (uop.imm5 != 5'd0)
                sh_c = uop.imm_val[31];
        end else begin
            case (uop.shift)
                shift_lsl: if (uop.imm5 != 5'd0) begin
                    op2  = lsl_w[31:0];
                    sh_c = lsl_w[32];
                end
                shift_lsr: begin
                    op2  = (uop.imm5 == 5'd0) ? 32'd0 : lsr_w[32:1];  // #0 means #32
                    sh_c = (uop.imm5 == 5'd0) ? rm_val[31] : lsr_w[0];
                end
                shift_asr: begin
                    op2  = (uop.imm5 == 5'd0) ? {32{rm_val[31]}} : asr_w[32:1];
                    sh_c = (uop.imm5 == 5'd0) ? rm_val[31] : asr_w[0];
                end
                default: begin
                    op2  = (uop.imm5 == 5'd0) ? {f.c, rm_val[31:1]} : ror_w;  // RRX at #0
                    sh_c = (uop.imm5 == 5'd0) ? rm_val[0] : ror_w[31];
                end
            endcase
        end
    end

    always_comb begin
        sum = 33'd0;
        nf  = f;
        case (uop.opcode)
            op_add:         sum = {1'b0, a} + {1'b0, op2};
            op_sub, op_cmp: sum = {1'b0, a} + {1'b0, ~op2} + 33'd1;
            default:        sum = 33'd0;
        endcase
        case (uop.opcode)
            op_and:  res = a & op2;
            op_eor:  res = a ^ op2;
            op_orr:  res = a | op2;
            op_mov:  res = op2;
            default: res = sum[31:0];
        endcase
        nf.n = res[31];
        nf.z = (res == 32'd0);
        if (uop.opcode == op_add) begin
            nf.c = sum[32];
            nf.v = (a[31] == op2[31]) && (res[31] != a[31]);
        end else if (uop.opcode == op_sub || uop.opcode == op_cmp) begin
            nf.c = sum[32];  // Set means no borrow
            nf.v = (a[31] != op2[31]) && (res[31] != a[31]);
        end else begin
            nf.c = sh_c;
        end
    end

    assign redirect.valid  = uop.valid && uop.is_branch && cond_ok;
    assign redirect.target = uop.target;

    assign result.valid     = uop.valid && !uop.is_branch && cond_ok;
    assign result.writes_rd = uop.writes_rd;
    assign result.rd        = uop.rd;
    assign result.data      = res;
    assign result.flags     = uop.set_flags ? nf : f;

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps
module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  core_pkg::fetch_t fetch,
    input  logic             cur_tag,
    output core_pkg::uop_t   uop
);
    import core_pkg::*;

    logic [31:0] instr_reg;
    logic        tag_reg;
    logic [31:0] pc_reg;
    instr_u      cur;
    dp_fmt_t     dp;
    br_fmt_t     br;
    op_e         op;
    logic        is_dp;
    logic        is_br;
    logic        op_ok;
    logic        word_ok;
    logic [63:0] rot_pair;

    // Instruction register, NOP whenever fetch has nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_reg <= nop_instr;
            tag_reg   <= 1'b0;
        end else if (fetch.valid) begin
            instr_reg <= fetch.instr;
            tag_reg   <= fetch.tag;
        end else begin
            instr_reg <= nop_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.valid)
            pc_reg <= fetch.pc;
    end

    // Stale tag means the word was fetched down a dead path
    assign cur = (tag_reg == cur_tag) ? instr_reg : nop_instr;
    assign dp  = cur.dp;
    assign br  = cur.br;
    assign op  = op_e'(dp.opcode);

    assign is_dp = (dp.cls == cls_dp);
    assign is_br = (br.cls == cls_br) && !br.link;  // No BL

    always_comb begin
        case (op)
            op_and, op_eor, op_sub, op_add, op_orr, op_mov, op_cmp: op_ok = 1'b1;
            default:                                                op_ok = 1'b0;
        endcase
    end

    // Register-specified shifts (bit 4 set) are not supported
    assign word_ok = (cur != nop_instr) && (dp.cond != 4'hf)
                   && ((is_dp && op_ok && (dp.imm || !dp.operand[4])) || is_br);

    // imm8 rotated right by 2*rot
    assign rot_pair = {24'd0, dp.operand[7:0], 24'd0, dp.operand[7:0]}
                      >> {dp.operand[11:8], 1'b0};

    always_comb begin
        uop.valid     = word_ok;
        uop.is_branch = is_br;
        uop.cond      = cond_e'(dp.cond);
        uop.opcode    = op;
        uop.set_flags = is_dp && (dp.s || op == op_cmp);
        uop.writes_rd = is_dp && (op != op_cmp);
        uop.rn        = dp.rn;
        uop.rd        = dp.rd;
        uop.rm        = dp.operand[3:0];
        uop.use_imm   = dp.imm;
        uop.shift     = dp.imm ? shift_ror : shift_e'(dp.operand[6:5]);
        // Immediates carry their rotate in imm5 so execute can form the carry
        uop.imm5      = dp.imm ? {dp.operand[11:8], 1'b0} : dp.operand[11:7];
        uop.imm_val   = rot_pair[31:0];
        uop.target    = pc_reg + 32'd8 + {{6{br.offset[23]}}, br.offset, 2'b00};
        uop.pc        = pc_reg;
    end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/10ps
module fetch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::redirect_t redirect,
    output logic                imem_req,
    output logic [31:0]         imem_addr,
    input  logic [31:0]         imem_rdata,
    input  logic                imem_ack,
    output core_pkg::fetch_t    fetch,
    output logic                cur_tag
);
    import core_pkg::*;

    typedef enum logic [1:0] {st_idle, st_wait_ack, st_wait_low} state_e;

    state_e      state;
    logic [31:0] pc;        // Next address to request
    logic        tag;
    logic        req_tag;   // Tag latched when the open request was issued
    logic [31:0] nxt_pc;
    logic        nxt_tag;
    logic        fetch_valid;
    logic        fetch_tag;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_word;

    // A redirect wins over the sequential pc, even mid-request
    assign nxt_pc  = redirect.valid ? redirect.target : pc;
    assign nxt_tag = tag ^ redirect.valid;
    assign cur_tag = tag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            pc          <= reset_pc;
            tag         <= 1'b0;
            req_tag     <= 1'b0;
            imem_req    <= 1'b0;
            imem_addr   <= reset_pc;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= nxt_pc;
            tag         <= nxt_tag;
            fetch_valid <= 1'b0;
            case (state)
                st_idle, st_wait_low: begin
                    if (!imem_ack) begin  // Ack seen low, open a new request
                        imem_req  <= 1'b1;
                        imem_addr <= nxt_pc;
                        req_tag   <= nxt_tag;
                        pc        <= nxt_pc + 32'd4;
                        state     <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (imem_ack) begin
                        imem_req    <= 1'b0;
                        fetch_valid <= 1'b1;
                        state       <= st_wait_low;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Captured word and where it came from
    always_ff @(posedge clk) begin
        if (state == st_wait_ack && imem_ack) begin
            fetch_word <= imem_rdata;
            fetch_pc   <= imem_addr;
            fetch_tag  <= req_tag;
        end
    end

    assign fetch.valid = fetch_valid;
    assign fetch.tag   = fetch_tag;
    assign fetch.pc    = fetch_pc;
    assign fetch.instr = fetch_word;

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

    // Hint-space MSR word, never retired
    localparam logic [31:0] nop_instr = 32'b1110_0011_0010_0000_1111_0000_0000_0000;
    localparam logic [31:0] reset_pc  = 32'h0000_0000;

    localparam logic [1:0] cls_dp = 2'b00;   // Data processing, bits 27:26
    localparam logic [2:0] cls_br = 3'b101;  // Branch, bits 27:25

    // ARM data-processing encodings, subset only
    typedef enum logic [3:0] {
        op_and = 4'b0000,
        op_eor = 4'b0001,
        op_sub = 4'b0010,
        op_add = 4'b0100,
        op_cmp = 4'b1010,
        op_orr = 4'b1100,
        op_mov = 4'b1101
    } op_e;

    typedef enum logic [3:0] {
        cond_eq, cond_ne, cond_cs, cond_cc,
        cond_mi, cond_pl, cond_vs, cond_vc,
        cond_hi, cond_ls, cond_ge, cond_lt,
        cond_gt, cond_le, cond_al
    } cond_e;

    typedef enum logic [1:0] {
        shift_lsl, shift_lsr, shift_asr, shift_ror
    } shift_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic [3:0]  cond;
        logic [1:0]  cls;
        logic        imm;      // Operand is rotated immediate
        logic [3:0]  opcode;
        logic        s;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] operand;
    } dp_fmt_t;

    typedef struct packed {
        logic [3:0]  cond;
        logic [2:0]  cls;
        logic        link;
        logic [23:0] offset;   // Word offset, signed
    } br_fmt_t;

    // Same fetched word, two views; cls picks the one that applies
    typedef union packed {
        dp_fmt_t dp;
        br_fmt_t br;
    } instr_u;

    typedef struct packed {
        logic        valid;
        logic        tag;
        logic [31:0] pc;
        instr_u      instr;
    } fetch_t;

    typedef struct packed {
        logic        valid;
        logic        is_branch;
        cond_e       cond;
        op_e         opcode;
        logic        set_flags;
        logic        writes_rd;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [3:0]  rm;
        logic        use_imm;
        shift_e      shift;
        logic [4:0]  imm5;
        logic [31:0] imm_val;
        logic [31:0] target;
        logic [31:0] pc;
    } uop_t;

    typedef struct packed {
        logic        valid;
        logic        writes_rd;
        logic [3:0]  rd;
        logic [31:0] data;
        flags_t      flags;
    } retire_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage
